/* dv/i2c_reg_trace.txt */
// op addr ack cnt last d0 d1 d2 d3 d4 d5 d6 d7
// op 1 write, 2 read with nak on the last byte, 3 write cut by a stop, 0 end
// ack 0 expects an ack on the address, 1 a nak; last 1 closes a test
// wrong address is ignored, register 3 stays zero
01 3b 01 02 00 03 aa 00 00 00 00 00 00
01 3a 00 01 00 03 00 00 00 00 00 00 00
02 3a 00 01 01 00 00 00 00 00 00 00 00
// pointer 2, four bytes, read back
01 3a 00 05 00 02 11 22 33 44 00 00 00
01 3a 00 01 00 02 00 00 00 00 00 00 00
02 3a 00 04 01 11 22 33 44 00 00 00 00
// wrap from 14, register 15 keeps the id
01 3a 00 04 00 0e 5a 6b 7c 00 00 00 00
01 3a 00 01 00 0e 00 00 00 00 00 00 00
02 3a 00 03 01 5a c5 7c 00 00 00 00 00
// read of the id register
01 3a 00 01 00 0f 00 00 00 00 00 00 00
02 3a 00 01 01 c5 00 00 00 00 00 00 00
// stop inside a byte, then a clean transfer
03 3a 00 02 00 05 99 a5 00 00 00 00 00
01 3a 00 02 00 06 de 00 00 00 00 00 00
01 3a 00 01 00 05 00 00 00 00 00 00 00
02 3a 00 02 01 99 de 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00

/* sources.f */
+incdir+common
common/i2c_pkg.sv
i2c_slave/i2c_line_sampler.sv
i2c_slave/i2c_slave_ctrl.sv
hdl/i2c_reg_bank.sv
hdl/i2c_reg_top.sv
dv/i2c_reg_assertions.sv
dv/i2c_reg_checker.sv
dv/i2c_reg_tb.sv

/* run.sh */
#!/bin/sh
# build and run the I2C register testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module i2c_reg_tb -o i2c_reg_sim
./obj_dir/i2c_reg_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi

/* dv/i2c_reg_tb.sv */
`timescale 1ns/100ps

`include "i2c_defines.svh"

module i2c_reg_tb;

    localparam int half_clks = 16;
    localparam int rec_len   = 13;
    localparam int max_recs  = 16;
    localparam int wait_max  = 200;

    // checker request codes
    localparam logic [2:0] req_ack  = 3'd1;
    localparam logic [2:0] req_byte = 3'd2;
    localparam logic [2:0] req_test = 3'd3;
    localparam logic [2:0] req_sum  = 3'd4;

    logic        clk = 1'b0;
    logic        reset;
    logic        scl;
    logic        sda_m;
    logic        sda;
    logic        sda_oe;
    logic [2:0]  chk_op;
    logic [7:0]  chk_val;
    logic        chk_done;
    logic [15:0] err_count;
    logic        timed_out;
    logic [7:0]  trace [rec_len*max_recs];

    // the DUT can only pull the open-drain line low
    assign sda = sda_m & ~sda_oe;

    i2c_reg_top i_i2c_reg_top (
        .clk      (clk),
        .reset    (reset),
        .dev_addr (`I2C_DEV_ADDR),
        .scl      (scl),
        .sda      (sda),
        .sda_oe   (sda_oe)
    );

    i2c_reg_checker i_i2c_reg_checker (
        .clk       (clk),
        .reset     (reset),
        .scl       (scl),
        .sda       (sda),
        .op        (chk_op),
        .val       (chk_val),
        .done      (chk_done),
        .err_count (err_count)
    );

    bind i2c_slave_ctrl i2c_reg_assertions i_i2c_reg_assertions (
        .clk    (clk),
        .reset  (reset),
        .ev     (ev),
        .req    (req),
        .active (active),
        .sda_oe (sda_oe)
    );

    always #4 clk = ~clk;

    // ------------------------------
    // bit-bang master
    // ------------------------------

    task automatic hold_half();
        repeat (half_clks) @(posedge clk);
    endtask

    // sda moves only while scl is low
    task automatic send_bit(input logic b);
        @(posedge clk);
        sda_m <= b;
        hold_half();
        scl <= 1'b1;
        hold_half();
        scl <= 1'b0;
    endtask

    task automatic send_start();
        hold_half();
        sda_m <= 1'b0;
        hold_half();
        scl <= 1'b0;
    endtask

    task automatic send_stop();
        @(posedge clk);
        sda_m <= 1'b0;
        hold_half();
        scl <= 1'b1;
        hold_half();
        sda_m <= 1'b1;
    endtask

    // eight data bits msb first, then the ack clock
    task automatic send_frame(input logic [7:0] data, input logic ack_level);
        for (int i = 7; i >= 0; i--) begin
            send_bit(data[i]);
        end
        send_bit(ack_level);
    endtask

    task automatic checker_call(input logic [2:0] op, input logic [7:0] val);
        int n;
        @(posedge clk);
        chk_op  <= op;
        chk_val <= val;
        n = 0;
        @(posedge clk);
        while (!chk_done && n < wait_max) begin
            @(posedge clk);
            n++;
        end
        if (!chk_done) begin
            $display("Timeout: the checker did not answer request %0d", op);
            timed_out = 1'b1;
        end
        chk_op <= 3'd0;
    endtask

    // ------------------------------
    // one trace record
    // ------------------------------

    task automatic run_record(input int base);
        logic [7:0] op;
        logic [6:0] addr;
        logic       exp_ack;
        int         cnt;
        op      = trace[base];
        addr    = trace[base + 1][6:0];
        exp_ack = trace[base + 2][0];
        cnt     = int'(trace[base + 3]);
        send_start();
        send_frame({addr, op == 8'h02}, 1'b1);
        checker_call(req_ack, {7'd0, exp_ack});
        if (op == 8'h02) begin
            if (!exp_ack) begin
                // master naks the last byte
                for (int i = 0; i < cnt; i++) begin
                    send_frame(8'hff, i == cnt - 1);
                    checker_call(req_byte, trace[base + 5 + i]);
                end
            end
        end else begin
            // an ignored address naks the data too
            for (int i = 0; i < cnt; i++) begin
                send_frame(trace[base + 5 + i], 1'b1);
                checker_call(req_ack, {7'd0, exp_ack});
            end
            if (op == 8'h03) begin
                for (int b = 7; b > 3; b--) begin
                    send_bit(trace[base + 5 + cnt][b]);
                end
            end
        end
        send_stop();
    endtask

    initial begin
        int base;
        int test_num;
        reset     = 1'b1;
        scl       = 1'b1;
        sda_m     = 1'b1;
        chk_op    = 3'd0;
        chk_val   = 8'h00;
        timed_out = 1'b0;
        test_num  = 0;
        $readmemh("dv/i2c_reg_trace.txt", trace);
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (int rec = 0; rec < max_recs; rec++) begin
            base = rec * rec_len;
            if (trace[base] == 8'h00 || timed_out) begin
                break;
            end
            run_record(base);
            if (trace[base + 4] == 8'h01) begin
                test_num++;
                checker_call(req_test, 8'(test_num));
            end
        end

        checker_call(req_sum, 8'h00);
        if (err_count == 16'd0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* dv/i2c_reg_checker.sv */
`timescale 1ns/100ps

module i2c_reg_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        scl,
    input  logic        sda,
    input  logic [2:0]  op,
    input  logic [7:0]  val,
    output logic        done,
    output logic [15:0] err_count
);

    logic       scl_d;
    logic [8:0] bits;
    int         checks;
    int         tests;
    int         tests_failed;
    int         test_errs;

    // sda at each scl rise, newest bit in bit 0
    always_ff @(posedge clk) begin
        if (reset) begin
            scl_d <= 1'b1;
            bits  <= '1;
        end else begin
            scl_d <= scl;
            if (scl && !scl_d) begin
                bits <= {bits[7:0], sda};
            end
        end
    end

    // ------------------------------
    // requests from the testbench
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            done         <= 1'b0;
            err_count    <= 16'd0;
            checks       <= 0;
            tests        <= 0;
            tests_failed <= 0;
            test_errs    <= 0;
        end else begin
            done <= 1'b0;
            if (op != 3'd0 && !done) begin
                done <= 1'b1;
                case (op)
                    3'd1: begin
                        // ack slot is the newest bit
                        checks <= checks + 1;
                        if (bits[0] !== val[0]) begin
                            $display("Mismatch at %0t: sda ack bit expected %b, got %b",
                                     $time, val[0], bits[0]);
                            err_count <= err_count + 16'd1;
                            test_errs <= test_errs + 1;
                        end
                    end
                    3'd2: begin
                        checks <= checks + 1;
                        if (bits[8:1] !== val) begin
                            $display("Mismatch at %0t: sda read byte expected %h, got %h",
                                     $time, val, bits[8:1]);
                            err_count <= err_count + 16'd1;
                            test_errs <= test_errs + 1;
                        end
                    end
                    3'd3: begin
                        tests <= tests + 1;
                        if (test_errs == 0) begin
                            $display("test %0d passed", val);
                        end else begin
                            $display("test %0d failed with %0d errors", val, test_errs);
                            tests_failed <= tests_failed + 1;
                        end
                        test_errs <= 0;
                    end
                    3'd4: begin
                        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                                 tests, tests_failed, checks, err_count);
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* dv/i2c_reg_assertions.sv */
`timescale 1ns/100ps

module i2c_reg_assertions (
    input logic                 clk,
    input logic                 reset,
    input i2c_pkg::line_event_t ev,
    input i2c_pkg::reg_req_t    req,
    input logic                 active,
    input logic                 sda_oe
);

    logic       scl_fall;
    logic [2:0] req_bits;

    assign scl_fall = ev.scl_fall;
    assign req_bits = {req.start, req.wr, req.rd_next};

    // sda drive only moves after a detected scl fall
    oe_after_fall: assert property (
        @(posedge clk) disable iff (reset)
        !$stable(sda_oe) |-> $past(scl_fall)
    ) else $error("sda_oe changed without a detected scl fall");

    one_request: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(req_bits)
    ) else $error("more than one request bit high");

    idle_released: assert property (
        @(posedge clk) disable iff (reset)
        !active |-> !sda_oe
    ) else $error("sda_oe high while the controller is idle");

endmodule

/* hdl/i2c_reg_top.sv */
`timescale 1ns/100ps

module i2c_reg_top (
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] dev_addr,
    input  logic       scl,
    input  logic       sda,
    output logic       sda_oe
);

    import i2c_pkg::*;

    line_event_t ev;
    reg_req_t    req;
    logic [7:0]  rdata;

    // ------------------------------
    // bit level
    // ------------------------------

    i2c_line_sampler i_i2c_line_sampler (
        .clk   (clk),
        .reset (reset),
        .scl   (scl),
        .sda   (sda),
        .ev    (ev)
    );

    // ------------------------------
    // byte level
    // ------------------------------

    i2c_slave_ctrl i_i2c_slave_ctrl (
        .clk      (clk),
        .reset    (reset),
        .dev_addr (dev_addr),
        .ev       (ev),
        .rdata    (rdata),
        .req      (req),
        .sda_oe   (sda_oe)
    );

    // register storage and pointer
    i2c_reg_bank i_i2c_reg_bank (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rdata (rdata)
    );

endmodule

/* hdl/i2c_reg_bank.sv */
`timescale 1ns/100ps

`include "i2c_defines.svh"

module i2c_reg_bank (
    input  logic              clk,
    input  logic              reset,
    input  i2c_pkg::reg_req_t req,
    output logic [7:0]        rdata
);

    localparam int reg_count = `I2C_REG_COUNT;
    localparam int ptr_w     = $clog2(reg_count);

    localparam logic [ptr_w-1:0] last_reg = ptr_w'(reg_count - 1);

    logic [7:0]       regs [reg_count];
    logic [ptr_w-1:0] ptr;
    logic             ptr_loaded;
    logic [ptr_w-1:0] ptr_inc;

    // wrap modulo the register count
    assign ptr_inc = (ptr == last_reg) ? '0 : ptr + 1'b1;

    // ------------------------------
    // pointer and storage
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr        <= '0;
            ptr_loaded <= 1'b0;
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= 8'h00;
            end
        end else begin
            if (req.start) begin
                ptr_loaded <= 1'b0;
            end

            if (req.wr) begin
                if (!ptr_loaded) begin
                    // first byte after the address is the pointer
                    ptr        <= req.wdata[ptr_w-1:0];
                    ptr_loaded <= 1'b1;
                end else begin
                    // id register ignores writes
                    if (ptr != last_reg) begin
                        regs[ptr] <= req.wdata;
                    end
                    ptr <= ptr_inc;
                end
            end

            if (req.rd_next) begin
                ptr <= ptr_inc;
            end
        end
    end

    // ------------------------------
    // read data
    // ------------------------------

    assign rdata = (ptr == last_reg) ? `I2C_ID_VALUE : regs[ptr];

endmodule

/* i2c_slave/i2c_slave_ctrl.sv */
`timescale 1ns/100ps

module i2c_slave_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [6:0]           dev_addr,
    input  i2c_pkg::line_event_t ev,
    input  logic [7:0]           rdata,
    output i2c_pkg::reg_req_t    req,
    output logic                 sda_oe
);

    import i2c_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_wdata,
        st_rdata
    } state_t;

    state_t     state;
    logic [3:0] bit_cnt;
    addr_byte_u rx;
    logic [7:0] tx;

    logic active;
    logic ack_slot;
    logic addr_match;
    logic shift_in;
    logic load_tx;
    logic shift_out;

    // ------------------------------
    // byte position decode
    // ------------------------------

    // bit_cnt counts data rises, 8 means the ack clock is next
    assign active     = (state != st_idle);
    assign ack_slot   = (bit_cnt == 4'd8);
    assign addr_match = (rx.f.dev_addr == dev_addr);

    assign shift_in  = active && ev.scl_rise && !ack_slot;
    assign load_tx   = (state == st_rdata) && ev.scl_fall && (bit_cnt == 4'd0);
    assign shift_out = (state == st_rdata) && ev.scl_fall && !ack_slot
                       && (bit_cnt != 4'd0);

    // ------------------------------
    // shift registers
    // ------------------------------

    always_ff @(posedge clk) begin
        if (shift_in) begin
            rx.raw <= {rx.raw[6:0], ev.sda};
        end
        // first read bit goes out straight from rdata
        if (load_tx) begin
            tx <= {rdata[6:0], 1'b1};
        end else if (shift_out) begin
            tx <= {tx[6:0], 1'b1};
        end
    end

    // ------------------------------
    // byte FSM
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            bit_cnt <= 4'd0;
            sda_oe  <= 1'b0;
            req     <= '0;
        end else begin
            req.start   <= 1'b0;
            req.wr      <= 1'b0;
            req.rd_next <= 1'b0;

            if (ev.stop) begin
                state  <= st_idle;
                sda_oe <= 1'b0;
            end else if (ev.start) begin
                // plain restart lands here too
                state   <= st_addr;
                bit_cnt <= 4'd0;
                sda_oe  <= 1'b0;
            end else if (active) begin

                // sample side
                if (ev.scl_rise) begin
                    if (!ack_slot) begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end else begin
                        bit_cnt <= 4'd0;
                        case (state)
                            st_addr: begin
                                state <= rx.f.rw ? st_rdata : st_wdata;
                            end
                            st_rdata: begin
                                // master ack asks for another byte
                                if (!ev.sda) begin
                                    req.rd_next <= 1'b1;
                                end else begin
                                    state <= st_idle;
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                end

                // drive side, sda only moves while scl is low
                if (ev.scl_fall) begin
                    case (state)
                        st_addr: begin
                            if (ack_slot && addr_match) begin
                                sda_oe    <= 1'b1;
                                req.start <= 1'b1;
                            end else if (ack_slot) begin
                                // not ours, leave sda released
                                sda_oe <= 1'b0;
                                state  <= st_idle;
                            end else begin
                                sda_oe <= 1'b0;
                            end
                        end
                        st_wdata: begin
                            if (ack_slot) begin
                                sda_oe    <= 1'b1;
                                req.wr    <= 1'b1;
                                req.wdata <= rx.raw;
                            end else begin
                                sda_oe <= 1'b0;
                            end
                        end
                        st_rdata: begin
                            if (ack_slot) begin
                                // let the master ack or nak
                                sda_oe <= 1'b0;
                            end else if (bit_cnt == 4'd0) begin
                                sda_oe <= ~rdata[7];
                            end else begin
                                sda_oe <= ~tx[7];
                            end
                        end
                        default: begin
                            sda_oe <= 1'b0;
                        end
                    endcase
                end
            end
        end
    end

endmodule

/* i2c_slave/i2c_line_sampler.sv */
`timescale 1ns/100ps

`include "i2c_defines.svh"

module i2c_line_sampler (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 scl,
    input  logic                 sda,
    output i2c_pkg::line_event_t ev
);

    localparam int tick_div = `I2C_TICK_DIV;
    localparam int cnt_w    = (tick_div > 0) ? $clog2(tick_div + 1) : 1;

    logic [1:0]       scl_sync;
    logic [1:0]       sda_sync;
    logic [cnt_w-1:0] tick_cnt;
    logic             tick;
    logic [1:0]       scl_hist;
    logic [1:0]       sda_hist;
    logic             hist_new;

    // ------------------------------
    // synchronizers and tick
    // ------------------------------

    assign tick = (tick_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            // idle bus is high on both lines
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
            tick_cnt <= cnt_w'(tick_div);
        end else begin
            scl_sync <= {scl_sync[0], scl};
            sda_sync <= {sda_sync[0], sda};
            if (tick) begin
                tick_cnt <= cnt_w'(tick_div);
            end else begin
                tick_cnt <= tick_cnt - 1'b1;
            end
        end
    end

    // ------------------------------
    // edge history
    // ------------------------------

    // bit 0 is the newest sample
    always_ff @(posedge clk) begin
        if (reset) begin
            scl_hist <= 2'b11;
            sda_hist <= 2'b11;
            hist_new <= 1'b0;
        end else begin
            hist_new <= tick;
            if (tick) begin
                scl_hist <= {scl_hist[0], scl_sync[1]};
                sda_hist <= {sda_hist[0], sda_sync[1]};
            end
        end
    end

    assign ev.scl_rise = hist_new && (scl_hist == 2'b01);
    assign ev.scl_fall = hist_new && (scl_hist == 2'b10);
    // sda moving while scl stays high
    assign ev.start    = hist_new && (scl_hist == 2'b11) && (sda_hist == 2'b10);
    assign ev.stop     = hist_new && (scl_hist == 2'b11) && (sda_hist == 2'b01);
    assign ev.sda      = sda_hist[0];

endmodule

/* common/i2c_pkg.sv */
package i2c_pkg;

    // ------------------------------
    // sampler to controller
    // ------------------------------

    // single-cycle event pulses, valid on a sampling tick only
    typedef struct packed {
        logic scl_rise;
        logic scl_fall;
        logic start;
        logic stop;
        logic sda;
    } line_event_t;

    // ------------------------------
    // receive shift register
    // ------------------------------

    // address byte: 7-bit device address, then the r/w bit
    typedef struct packed {
        logic [6:0] dev_addr;
        logic       rw;
    } addr_fields_t;

    // same byte seen as data or as an address
    typedef union packed {
        logic [7:0]   raw;
        addr_fields_t f;
    } addr_byte_u;

    // ------------------------------
    // controller to register bank
    // ------------------------------

    typedef struct packed {
        logic       start;
        logic       wr;
        logic       rd_next;
        logic [7:0] wdata;
    } reg_req_t;

endpackage

/* common/i2c_defines.svh */
`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// ------------------------------
// device addressing
// ------------------------------

// default 7-bit slave address
`define I2C_DEV_ADDR 7'h3a

// ------------------------------
// line sampling
// ------------------------------

// sampling tick every I2C_TICK_DIV+1 clocks
`define I2C_TICK_DIV 3

// ------------------------------
// register bank
// ------------------------------

`define I2C_REG_COUNT 16

// read-only value of the last register
`define I2C_ID_VALUE 8'hc5

`endif
